// File: gemm_cfg_macros.svh
// =========================================================================
// GEMM configuration bank definitions
// Register address map, bus widths and field widths of the host port
// =========================================================================
`ifndef GEMM_CFG_MACROS_SVH
`define GEMM_CFG_MACROS_SVH

// Bus and field widths
`define CFG_ADDR_W 8
`define CFG_DATA_W 32
`define CFG_DIM_W  16
`define CFG_TILE_W 13
`define CFG_SRAM_W 16
`define CFG_DRAM_W 32
`define CFG_MODE_W 2

// Register address map
`define CFG_ADDR_CTRL        8'h00
`define CFG_ADDR_STATUS      8'h04
`define CFG_ADDR_MATRIX_M    8'h08
`define CFG_ADDR_MATRIX_N    8'h0C
`define CFG_ADDR_MATRIX_K    8'h10
`define CFG_ADDR_TILE_MN     8'h14
`define CFG_ADDR_BUF_MODE    8'h18
`define CFG_ADDR_DRAM_A      8'h1C
`define CFG_ADDR_DRAM_B      8'h20
`define CFG_ADDR_DRAM_C      8'h24
`define CFG_ADDR_SRAM_A_PING 8'h28
`define CFG_ADDR_SRAM_A_PONG 8'h2C
`define CFG_ADDR_SRAM_B_PING 8'h30
`define CFG_ADDR_SRAM_B_PONG 8'h34
`define CFG_ADDR_SRAM_C      8'h38
`define CFG_ADDR_BASELINE    8'h3C
`define CFG_ADDR_TILE_K      8'h58

`endif

// File: gemm_cfg_pkg.sv
// =========================================================================
// GEMM configuration bank types
// Host request, configuration structs and the register-select decode
// =========================================================================
`default_nettype none
`include "gemm_cfg_macros.svh"

package gemm_cfg_pkg;

    // One host port cycle
    typedef struct packed {
        logic [`CFG_ADDR_W-1:0] addr;
        logic [`CFG_DATA_W-1:0] wdata;
        logic                   wen;
        logic                   ren;
    } host_req_t;

    typedef struct packed {
        logic [`CFG_DIM_W-1:0] m;
        logic [`CFG_DIM_W-1:0] n;
        logic [`CFG_DIM_W-1:0] k;
    } gemm_dims_t;

    typedef struct packed {
        logic [`CFG_TILE_W-1:0] m;
        logic [`CFG_TILE_W-1:0] n;
        logic [`CFG_TILE_W-1:0] k;
    } tile_dims_t;

    typedef struct packed {
        logic [`CFG_DRAM_W-1:0] a;
        logic [`CFG_DRAM_W-1:0] b;
        logic [`CFG_DRAM_W-1:0] c;
    } dram_bases_t;

    typedef struct packed {
        logic [`CFG_SRAM_W-1:0] a_ping;
        logic [`CFG_SRAM_W-1:0] a_pong;
        logic [`CFG_SRAM_W-1:0] b_ping;
        logic [`CFG_SRAM_W-1:0] b_pong;
        logic [`CFG_SRAM_W-1:0] c;
    } sram_bases_t;

    // Everything the scheduler sees
    typedef struct packed {
        gemm_dims_t             dims;
        tile_dims_t             tiles;
        logic [`CFG_MODE_W-1:0] buffering_mode;
        logic                   baseline_mode;
        dram_bases_t            dram;
        sram_bases_t            sram;
    } gemm_cfg_t;

    typedef enum logic [4:0] {
        REG_CTRL,
        REG_STATUS,
        REG_MATRIX_M,
        REG_MATRIX_N,
        REG_MATRIX_K,
        REG_TILE_MN,
        REG_BUF_MODE,
        REG_DRAM_A,
        REG_DRAM_B,
        REG_DRAM_C,
        REG_SRAM_A_PING,
        REG_SRAM_A_PONG,
        REG_SRAM_B_PING,
        REG_SRAM_B_PONG,
        REG_SRAM_C,
        REG_BASELINE,
        REG_TILE_K,
        REG_UNMAPPED
    } reg_sel_e;

    // Address to register select, shared by write and read decode
    function automatic reg_sel_e decode_reg(input logic [`CFG_ADDR_W-1:0] addr);
        reg_sel_e sel;
        case (addr)
            `CFG_ADDR_CTRL:        sel = REG_CTRL;
            `CFG_ADDR_STATUS:      sel = REG_STATUS;
            `CFG_ADDR_MATRIX_M:    sel = REG_MATRIX_M;
            `CFG_ADDR_MATRIX_N:    sel = REG_MATRIX_N;
            `CFG_ADDR_MATRIX_K:    sel = REG_MATRIX_K;
            `CFG_ADDR_TILE_MN:     sel = REG_TILE_MN;
            `CFG_ADDR_BUF_MODE:    sel = REG_BUF_MODE;
            `CFG_ADDR_DRAM_A:      sel = REG_DRAM_A;
            `CFG_ADDR_DRAM_B:      sel = REG_DRAM_B;
            `CFG_ADDR_DRAM_C:      sel = REG_DRAM_C;
            `CFG_ADDR_SRAM_A_PING: sel = REG_SRAM_A_PING;
            `CFG_ADDR_SRAM_A_PONG: sel = REG_SRAM_A_PONG;
            `CFG_ADDR_SRAM_B_PING: sel = REG_SRAM_B_PING;
            `CFG_ADDR_SRAM_B_PONG: sel = REG_SRAM_B_PONG;
            `CFG_ADDR_SRAM_C:      sel = REG_SRAM_C;
            `CFG_ADDR_BASELINE:    sel = REG_BASELINE;
            `CFG_ADDR_TILE_K:      sel = REG_TILE_K;
            default:               sel = REG_UNMAPPED;
        endcase
        return sel;
    endfunction

endpackage

`default_nettype wire

// File: gemm_cfg_field_regs.sv
// =========================================================================
// GEMM configuration field registers
// Decodes host writes and holds every configuration field, writes are
// accepted only while the scheduler is idle
// =========================================================================
`default_nettype none
`include "gemm_cfg_macros.svh"

module gemm_cfg_field_regs (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire gemm_cfg_pkg::host_req_t host,
    input  wire logic                   busy,
    output gemm_cfg_pkg::gemm_cfg_t     cfg
);

    import gemm_cfg_pkg::*;

    reg_sel_e wr_sel;
    logic     wr_en;

    assign wr_sel = decode_reg(host.addr);

    // Config is frozen while a GEMM is running
    assign wr_en = host.wen && !busy;

    // =========================================================================
    // Field storage
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg <= '0;
        end else if (wr_en) begin
            case (wr_sel)
                REG_MATRIX_M: cfg.dims.m <= host.wdata[`CFG_DIM_W-1:0];
                REG_MATRIX_N: cfg.dims.n <= host.wdata[`CFG_DIM_W-1:0];
                REG_MATRIX_K: cfg.dims.k <= host.wdata[`CFG_DIM_W-1:0];
                // Tile M and N share one word
                REG_TILE_MN: begin
                    cfg.tiles.m <= host.wdata[`CFG_TILE_W-1:0];
                    cfg.tiles.n <= host.wdata[2*`CFG_TILE_W-1:`CFG_TILE_W];
                end
                REG_BUF_MODE: cfg.buffering_mode <= host.wdata[`CFG_MODE_W-1:0];
                REG_DRAM_A: cfg.dram.a <= host.wdata[`CFG_DRAM_W-1:0];
                REG_DRAM_B: cfg.dram.b <= host.wdata[`CFG_DRAM_W-1:0];
                REG_DRAM_C: cfg.dram.c <= host.wdata[`CFG_DRAM_W-1:0];
                REG_SRAM_A_PING: cfg.sram.a_ping <= host.wdata[`CFG_SRAM_W-1:0];
                REG_SRAM_A_PONG: cfg.sram.a_pong <= host.wdata[`CFG_SRAM_W-1:0];
                REG_SRAM_B_PING: cfg.sram.b_ping <= host.wdata[`CFG_SRAM_W-1:0];
                REG_SRAM_B_PONG: cfg.sram.b_pong <= host.wdata[`CFG_SRAM_W-1:0];
                REG_SRAM_C: cfg.sram.c <= host.wdata[`CFG_SRAM_W-1:0];
                REG_BASELINE: cfg.baseline_mode <= host.wdata[0];
                // Tile K word also carries a copy of the buffering mode
                REG_TILE_K: begin
                    cfg.tiles.k <= host.wdata[`CFG_TILE_W-1:0];
                    cfg.buffering_mode <=
                        host.wdata[`CFG_TILE_W+`CFG_MODE_W-1:`CFG_TILE_W];
                end
                // CTRL, STATUS and holes hold no field
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: gemm_cfg_validator.sv
// =========================================================================
// GEMM tiling validator
// Flags a configuration as legal when every dimension is non-zero and
// each matrix dimension is a whole multiple of its tile
// =========================================================================
`default_nettype none
`include "gemm_cfg_macros.svh"

module gemm_cfg_validator (
    input  wire gemm_cfg_pkg::gemm_cfg_t cfg,
    output logic                         config_valid
);

    // One axis of the tiling check
    function automatic logic axis_ok(input logic [`CFG_DIM_W-1:0]  dim,
                                     input logic [`CFG_TILE_W-1:0] tile);
        logic [`CFG_DIM_W-1:0] tile_ext;
        tile_ext = {{(`CFG_DIM_W-`CFG_TILE_W){1'b0}}, tile};
        // Zero tile short-circuits before the remainder matters
        return (dim != '0) && (tile != '0) && ((dim % tile_ext) == '0);
    endfunction

    logic m_ok;
    logic n_ok;
    logic k_ok;

    assign m_ok = axis_ok(cfg.dims.m, cfg.tiles.m);
    assign n_ok = axis_ok(cfg.dims.n, cfg.tiles.n);
    assign k_ok = axis_ok(cfg.dims.k, cfg.tiles.k);

    assign config_valid = m_ok && n_ok && k_ok;

endmodule

`default_nettype wire

// File: gemm_cfg_launch_ctrl.sv
// =========================================================================
// GEMM launch control
// CTRL register decode, one-cycle start and reset pulses, sticky error
// =========================================================================
`default_nettype none
`include "gemm_cfg_macros.svh"

module gemm_cfg_launch_ctrl (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire gemm_cfg_pkg::host_req_t host,
    input  wire logic                    busy,
    input  wire logic                    config_valid,
    input  wire logic                    error_in,
    output logic                         start,
    output logic                         ctrl_reset,
    output logic                         error_out
);

    logic ctrl_wr;
    logic start_req;

    assign ctrl_wr   = host.wen && (host.addr == `CFG_ADDR_CTRL);
    // A start while busy is simply dropped
    assign start_req = ctrl_wr && host.wdata[0] && !busy;

    // =========================================================================
    // Pulses
    // =========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start      <= 1'b0;
            ctrl_reset <= 1'b0;
        end else begin
            start <= start_req && config_valid;
            // Reset bit is honored even mid-run so software can abort
            ctrl_reset <= ctrl_wr && host.wdata[1];
        end
    end

    // =========================================================================
    // Sticky error
    // =========================================================================
    // Clear by controller reset wins, then datapath error, then bad start
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            error_out <= 1'b0;
        end else if (ctrl_reset) begin
            error_out <= 1'b0;
        end else if (error_in) begin
            error_out <= 1'b1;
        end else if (start_req && !config_valid) begin
            error_out <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: gemm_cfg_read_port.sv
// =========================================================================
// GEMM configuration read port
// Latches the read address on ren and returns the selected register
// one edge later, fields packed back into their mapped positions
// =========================================================================
`default_nettype none
`include "gemm_cfg_macros.svh"

module gemm_cfg_read_port (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire gemm_cfg_pkg::host_req_t host,
    input  wire gemm_cfg_pkg::gemm_cfg_t cfg,
    input  wire logic                    start,
    input  wire logic                    ctrl_reset,
    input  wire logic                    error_out,
    input  wire logic                    busy,
    input  wire logic                    done,
    output logic [`CFG_DATA_W-1:0]       rdata
);

    import gemm_cfg_pkg::*;

    reg_sel_e               rd_sel;
    logic [`CFG_DATA_W-1:0] rd_word;

    // Selection holds until the next ren
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_sel <= REG_CTRL;
        end else if (host.ren) begin
            rd_sel <= decode_reg(host.addr);
        end
    end

    // =========================================================================
    // Read mux
    // =========================================================================
    always_comb begin
        rd_word = '0;
        case (rd_sel)
            REG_CTRL: begin
                rd_word[0] = start;
                rd_word[1] = ctrl_reset;
            end
            REG_STATUS: begin
                rd_word[0] = busy;
                rd_word[1] = done;
                rd_word[2] = error_out;
            end
            REG_MATRIX_M: rd_word[`CFG_DIM_W-1:0] = cfg.dims.m;
            REG_MATRIX_N: rd_word[`CFG_DIM_W-1:0] = cfg.dims.n;
            REG_MATRIX_K: rd_word[`CFG_DIM_W-1:0] = cfg.dims.k;
            REG_TILE_MN: begin
                rd_word[`CFG_TILE_W-1:0]              = cfg.tiles.m;
                rd_word[2*`CFG_TILE_W-1:`CFG_TILE_W] = cfg.tiles.n;
            end
            REG_BUF_MODE: rd_word[`CFG_MODE_W-1:0] = cfg.buffering_mode;
            REG_DRAM_A: rd_word[`CFG_DRAM_W-1:0] = cfg.dram.a;
            REG_DRAM_B: rd_word[`CFG_DRAM_W-1:0] = cfg.dram.b;
            REG_DRAM_C: rd_word[`CFG_DRAM_W-1:0] = cfg.dram.c;
            REG_SRAM_A_PING: rd_word[`CFG_SRAM_W-1:0] = cfg.sram.a_ping;
            REG_SRAM_A_PONG: rd_word[`CFG_SRAM_W-1:0] = cfg.sram.a_pong;
            REG_SRAM_B_PING: rd_word[`CFG_SRAM_W-1:0] = cfg.sram.b_ping;
            REG_SRAM_B_PONG: rd_word[`CFG_SRAM_W-1:0] = cfg.sram.b_pong;
            REG_SRAM_C: rd_word[`CFG_SRAM_W-1:0] = cfg.sram.c;
            REG_BASELINE: rd_word[0] = cfg.baseline_mode;
            REG_TILE_K: begin
                rd_word[`CFG_TILE_W-1:0] = cfg.tiles.k;
                rd_word[`CFG_TILE_W+`CFG_MODE_W-1:`CFG_TILE_W] = cfg.buffering_mode;
            end
            // Unmapped reads back zero
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else begin
            rdata <= rd_word;
        end
    end

endmodule

`default_nettype wire

// File: gemm_config_regs.sv
// =========================================================================
// GEMM configuration register bank
// Host-programmable tiling configuration with validated start
// =========================================================================
`default_nettype none
`include "gemm_cfg_macros.svh"

module gemm_config_regs (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire gemm_cfg_pkg::host_req_t host,
    input  wire logic                    busy,
    input  wire logic                    done,
    input  wire logic                    error_in,
    output gemm_cfg_pkg::gemm_cfg_t      cfg,
    output logic                         start,
    output logic                         ctrl_reset,
    output logic                         error_out,
    output logic [`CFG_DATA_W-1:0]       rdata
);

    logic config_valid;

    gemm_cfg_field_regs u_field_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .host  (host),
        .busy  (busy),
        .cfg   (cfg)
    );

    gemm_cfg_validator u_validator (
        .cfg          (cfg),
        .config_valid (config_valid)
    );

    gemm_cfg_launch_ctrl u_launch_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .host         (host),
        .busy         (busy),
        .config_valid (config_valid),
        .error_in     (error_in),
        .start        (start),
        .ctrl_reset   (ctrl_reset),
        .error_out    (error_out)
    );

    gemm_cfg_read_port u_read_port (
        .clk        (clk),
        .rst_n      (rst_n),
        .host       (host),
        .cfg        (cfg),
        .start      (start),
        .ctrl_reset (ctrl_reset),
        .error_out  (error_out),
        .busy       (busy),
        .done       (done),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

// File: gemm_config_regs_asserts.sv
// ============================================================================
// GEMM configuration bank checker
// Shadow register model with concurrent assertions, bound to the top level
// ============================================================================
`default_nettype none
`include "gemm_cfg_macros.svh"

module gemm_config_regs_asserts (
    input wire logic                    clk,
    input wire logic                    rst_n,
    input wire gemm_cfg_pkg::host_req_t host,
    input wire logic                    busy,
    input wire logic                    done,
    input wire logic                    error_in,
    input wire gemm_cfg_pkg::gemm_cfg_t cfg,
    input wire logic                    start,
    input wire logic                    ctrl_reset,
    input wire logic                    error_out,
    input wire logic [`CFG_DATA_W-1:0]  rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    import gemm_cfg_pkg::*;

    int unsigned            fail_count = 0;
    gemm_cfg_t              shadow;
    logic [`CFG_ADDR_W-1:0] rd_addr_q;
    logic [`CFG_DATA_W-1:0] exp_word;
    logic [`CFG_DATA_W-1:0] exp_rdata;
    logic                   ctrl_wr;
    logic                   start_req;
    logic                   tiling_ok;

    assign ctrl_wr   = host.wen && (host.addr == `CFG_ADDR_CTRL);
    assign start_req = ctrl_wr && host.wdata[0] && !busy;

    // Legal tiling: no zero sizes, every matrix size a multiple of its tile
    assign tiling_ok = (shadow.tiles.m != 0) && (shadow.tiles.n != 0) &&
                       (shadow.tiles.k != 0) && (shadow.dims.m != 0) &&
                       (shadow.dims.n != 0) && (shadow.dims.k != 0) &&
                       (shadow.dims.m % {3'b000, shadow.tiles.m} == 0) &&
                       (shadow.dims.n % {3'b000, shadow.tiles.n} == 0) &&
                       (shadow.dims.k % {3'b000, shadow.tiles.k} == 0);

    // ========================================================================
    // Shadow model of the field registers and the read path
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shadow <= '0;
        end else if (host.wen && !busy) begin
            case (host.addr)
                `CFG_ADDR_MATRIX_M:    shadow.dims.m <= host.wdata[15:0];
                `CFG_ADDR_MATRIX_N:    shadow.dims.n <= host.wdata[15:0];
                `CFG_ADDR_MATRIX_K:    shadow.dims.k <= host.wdata[15:0];
                `CFG_ADDR_TILE_MN: begin
                    shadow.tiles.m <= host.wdata[12:0];
                    shadow.tiles.n <= host.wdata[25:13];
                end
                `CFG_ADDR_BUF_MODE:    shadow.buffering_mode <= host.wdata[1:0];
                `CFG_ADDR_DRAM_A:      shadow.dram.a <= host.wdata;
                `CFG_ADDR_DRAM_B:      shadow.dram.b <= host.wdata;
                `CFG_ADDR_DRAM_C:      shadow.dram.c <= host.wdata;
                `CFG_ADDR_SRAM_A_PING: shadow.sram.a_ping <= host.wdata[15:0];
                `CFG_ADDR_SRAM_A_PONG: shadow.sram.a_pong <= host.wdata[15:0];
                `CFG_ADDR_SRAM_B_PING: shadow.sram.b_ping <= host.wdata[15:0];
                `CFG_ADDR_SRAM_B_PONG: shadow.sram.b_pong <= host.wdata[15:0];
                `CFG_ADDR_SRAM_C:      shadow.sram.c <= host.wdata[15:0];
                `CFG_ADDR_BASELINE:    shadow.baseline_mode <= host.wdata[0];
                `CFG_ADDR_TILE_K: begin
                    shadow.tiles.k        <= host.wdata[12:0];
                    shadow.buffering_mode <= host.wdata[14:13];
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        case (rd_addr_q)
            `CFG_ADDR_CTRL:        exp_word = {30'd0, ctrl_reset, start};
            `CFG_ADDR_STATUS:      exp_word = {29'd0, error_out, done, busy};
            `CFG_ADDR_MATRIX_M:    exp_word = {16'd0, shadow.dims.m};
            `CFG_ADDR_MATRIX_N:    exp_word = {16'd0, shadow.dims.n};
            `CFG_ADDR_MATRIX_K:    exp_word = {16'd0, shadow.dims.k};
            `CFG_ADDR_TILE_MN:     exp_word = {6'd0, shadow.tiles.n, shadow.tiles.m};
            `CFG_ADDR_BUF_MODE:    exp_word = {30'd0, shadow.buffering_mode};
            `CFG_ADDR_DRAM_A:      exp_word = shadow.dram.a;
            `CFG_ADDR_DRAM_B:      exp_word = shadow.dram.b;
            `CFG_ADDR_DRAM_C:      exp_word = shadow.dram.c;
            `CFG_ADDR_SRAM_A_PING: exp_word = {16'd0, shadow.sram.a_ping};
            `CFG_ADDR_SRAM_A_PONG: exp_word = {16'd0, shadow.sram.a_pong};
            `CFG_ADDR_SRAM_B_PING: exp_word = {16'd0, shadow.sram.b_ping};
            `CFG_ADDR_SRAM_B_PONG: exp_word = {16'd0, shadow.sram.b_pong};
            `CFG_ADDR_SRAM_C:      exp_word = {16'd0, shadow.sram.c};
            `CFG_ADDR_BASELINE:    exp_word = {31'd0, shadow.baseline_mode};
            `CFG_ADDR_TILE_K:
                exp_word = {17'd0, shadow.buffering_mode, shadow.tiles.k};
            default:               exp_word = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_addr_q <= `CFG_ADDR_CTRL;
            exp_rdata <= '0;
        end else begin
            if (host.ren) begin
                rd_addr_q <= host.addr;
            end
            exp_rdata <= exp_word;
        end
    end

    // ========================================================================
    // Assertions
    // ========================================================================
    a_cfg_match: assert property (@(posedge clk) disable iff (!rst_n) cfg == shadow)
        else begin $error("cfg differs from shadow model"); fail_count++; end

    a_rdata_match: assert property (@(posedge clk) disable iff (!rst_n)
        rdata == exp_rdata)
        else begin $error("rdata differs from expected word"); fail_count++; end

    a_start_rule: assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> start == $past(start_req && tiling_ok))
        else begin $error("start pulse wrong"); fail_count++; end

    a_ctrl_reset_rule: assert property (@(posedge clk) disable iff (!rst_n)
        1'b1 |=> ctrl_reset == $past(ctrl_wr && host.wdata[1]))
        else begin $error("ctrl_reset pulse wrong"); fail_count++; end

    a_reset_clears: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_reset |=> !error_out)
        else begin $error("error not cleared by ctrl_reset"); fail_count++; end

    a_error_set: assert property (@(posedge clk) disable iff (!rst_n)
        !ctrl_reset && (error_in || (start_req && !tiling_ok)) |=> error_out)
        else begin $error("error not set"); fail_count++; end

    a_error_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !ctrl_reset && !error_in && !(start_req && !tiling_ok) |=>
        error_out == $past(error_out))
        else begin $error("error changed without cause"); fail_count++; end

endmodule

`default_nettype wire

// File: tb_gemm_config_regs.sv
// ============================================================================
// GEMM configuration bank testbench
// Drives host writes, reads, starts and errors; the bound checker compares
// ============================================================================
`default_nettype none
`include "gemm_cfg_macros.svh"

module tb_gemm_config_regs;
    timeunit 1ns;
    timeprecision 100ps;

    import gemm_cfg_pkg::*;

    localparam int PERIOD      = 4;
    localparam int TEST_CYCLES = 1500;
    localparam int MARGIN_NS   = 200;

    logic                   clk;
    logic                   rst_n;
    host_req_t              host;
    logic                   busy;
    logic                   done;
    logic                   error_in;
    gemm_cfg_t              cfg;
    logic                   start;
    logic                   ctrl_reset;
    logic                   error_out;
    logic [`CFG_DATA_W-1:0] rdata;
    integer                 seed = 32'hcd06;

    logic [`CFG_ADDR_W-1:0] field_addrs [15] = '{
        `CFG_ADDR_MATRIX_M, `CFG_ADDR_MATRIX_N, `CFG_ADDR_MATRIX_K,
        `CFG_ADDR_TILE_MN, `CFG_ADDR_BUF_MODE, `CFG_ADDR_DRAM_A,
        `CFG_ADDR_DRAM_B, `CFG_ADDR_DRAM_C, `CFG_ADDR_SRAM_A_PING,
        `CFG_ADDR_SRAM_A_PONG, `CFG_ADDR_SRAM_B_PING, `CFG_ADDR_SRAM_B_PONG,
        `CFG_ADDR_SRAM_C, `CFG_ADDR_BASELINE, `CFG_ADDR_TILE_K
    };

    gemm_config_regs UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .host       (host),
        .busy       (busy),
        .done       (done),
        .error_in   (error_in),
        .cfg        (cfg),
        .start      (start),
        .ctrl_reset (ctrl_reset),
        .error_out  (error_out),
        .rdata      (rdata)
    );

    bind gemm_config_regs gemm_config_regs_asserts u_asserts (
        .clk (clk), .rst_n (rst_n), .host (host), .busy (busy), .done (done),
        .error_in (error_in), .cfg (cfg), .start (start),
        .ctrl_reset (ctrl_reset), .error_out (error_out), .rdata (rdata)
    );

    always #(PERIOD / 2) clk = ~clk;

    // Stop at the first assertion failure
    always @(UUT.u_asserts.fail_count) begin
        if (UUT.u_asserts.fail_count != 0) begin
            $display("ERROR @ %0t ns: checker assertion failed", $time);
            $display("Simulation FAILED");
            $fatal(1, "stopping on first error");
        end
    end

    initial begin
        #(TEST_CYCLES * PERIOD + MARGIN_NS);
        $display("Watchdog expired before the test sequence completed");
        $display("Simulation FAILED");
        $fatal(1, "timeout");
    end

    // ========================================================================
    // Host port tasks
    // ========================================================================
    task automatic write_reg(input logic [`CFG_ADDR_W-1:0] addr,
                             input logic [`CFG_DATA_W-1:0] data);
        @(posedge clk);
        #1;
        host.addr  = addr;
        host.wdata = data;
        host.wen   = 1'b1;
        @(posedge clk);
        #1;
        host.wen = 1'b0;
    endtask

    task automatic read_reg(input logic [`CFG_ADDR_W-1:0] addr);
        @(posedge clk);
        #1;
        host.addr = addr;
        host.ren  = 1'b1;
        @(posedge clk);
        #1;
        host.ren = 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic set_busy(input logic value);
        @(posedge clk);
        #1;
        busy = value;
    endtask

    task automatic program_tiling(input logic [15:0] m, input logic [15:0] n,
                                  input logic [15:0] k, input logic [12:0] tm,
                                  input logic [12:0] tn, input logic [12:0] tk);
        write_reg(`CFG_ADDR_MATRIX_M, {16'd0, m});
        write_reg(`CFG_ADDR_MATRIX_N, {16'd0, n});
        write_reg(`CFG_ADDR_MATRIX_K, {16'd0, k});
        write_reg(`CFG_ADDR_TILE_MN, {6'd0, tn, tm});
        write_reg(`CFG_ADDR_TILE_K, {17'd0, 2'b01, tk});
    endtask

    task automatic program_random_legal();
        logic [12:0] tm;
        logic [12:0] tn;
        logic [12:0] tk;
        tm = 13'(($random(seed) & 15) + 1);
        tn = 13'(($random(seed) & 15) + 1);
        tk = 13'(($random(seed) & 15) + 1);
        program_tiling(16'(tm * (($random(seed) & 7) + 1)),
                       16'(tn * (($random(seed) & 7) + 1)),
                       16'(tk * (($random(seed) & 7) + 1)), tm, tn, tk);
    endtask

    task automatic pulse_error_in();
        @(posedge clk);
        #1;
        error_in = 1'b1;
        @(posedge clk);
        #1;
        error_in = 1'b0;
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        host     = '0;
        busy     = 1'b0;
        done     = 1'b0;
        error_in = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Random field writes and readback, then unmapped holes
        foreach (field_addrs[i]) begin
            write_reg(field_addrs[i], $random(seed));
            read_reg(field_addrs[i]);
        end
        read_reg(8'h40);
        read_reg(8'h5C);
        read_reg(8'hFC);

        // Writes while busy are dropped
        set_busy(1'b1);
        foreach (field_addrs[i]) begin
            write_reg(field_addrs[i], $random(seed));
            read_reg(field_addrs[i]);
        end
        set_busy(1'b0);

        // Legal starts while idle and while busy
        // CTRL stays selected so the start pulse shows on rdata
        repeat (4) begin
            program_random_legal();
            read_reg(`CFG_ADDR_CTRL);
            write_reg(`CFG_ADDR_CTRL, 32'h1);
            set_busy(1'b1);
            write_reg(`CFG_ADDR_CTRL, 32'h1);
            set_busy(1'b0);
        end

        // Zero dimension, then a non-divisible one
        program_tiling(16'd0, 16'd32, 16'd48, 13'd16, 13'd8, 13'd16);
        write_reg(`CFG_ADDR_CTRL, 32'h1);
        read_reg(`CFG_ADDR_CTRL);
        write_reg(`CFG_ADDR_CTRL, 32'h2);
        program_tiling(16'd65, 16'd32, 16'd48, 13'd16, 13'd8, 13'd16);
        write_reg(`CFG_ADDR_CTRL, 32'h1);
        read_reg(`CFG_ADDR_STATUS);

        // Controller reset, also while busy, then datapath error
        set_busy(1'b1);
        write_reg(`CFG_ADDR_CTRL, 32'h2);
        set_busy(1'b0);
        pulse_error_in();
        read_reg(`CFG_ADDR_STATUS);

        // Status bits for every busy and done combination
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            #1;
            busy = i[0];
            done = i[1];
            read_reg(`CFG_ADDR_STATUS);
        end
        set_busy(1'b0);
        repeat (4) @(posedge clk);

        if (UUT.u_asserts.fail_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Simulation FAILED");
            $fatal(1, "checker reported errors");
        end
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
gemm_cfg_pkg.sv
gemm_cfg_field_regs.sv
gemm_cfg_validator.sv
gemm_cfg_launch_ctrl.sv
gemm_cfg_read_port.sv
gemm_config_regs.sv
gemm_config_regs_asserts.sv
tb_gemm_config_regs.sv

// File: Makefile
# Verilator build and run for the GEMM configuration bank

SIM       = verilator
SIM_FLAGS = --binary --timing --assert
TOP       = tb_gemm_config_regs
FILELIST  = files.f
RUN_FLAGS = +verilator+error+limit+1000
BIN       = obj_dir/V$(TOP)
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

$(BIN): $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

test: $(BIN)
	-./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
